// File: regfile_top.f
+incdir+.
regfile_pkg.sv
bus_port.sv
ctrl_regs.sv
multibyte_reg.sv
readout_fifo.sv
dataset_reader.sv
regfile_top.sv
tb_regfile_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_regfile_top
FILELIST  := regfile_top.f
FLAGS     := --binary --timing -Wno-fatal
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_regfile_top.sv
//----------------------------
// Testbench for the register file
// Shadow model of every register and of the readout FIFO
// Stops at the first mismatch or after MAX_CYCLES clocks
//----------------------------
`timescale 1ns/1ps
`include "regfile_settings.svh"

module tb_regfile_top;
    import regfile_pkg::*;

    localparam int MAX_CYCLES  = 5000;
    localparam int FIFO_DEPTH  = `FIFO_DEPTH;
    localparam int DATASET_LEN = `DATASET_LEN;
    localparam addr_t ADDR_UNMAPPED = 8'd200;

    logic        clk;
    logic        arst_n;
    logic        req;
    bus_req_t    req_data;
    logic        ack;
    byte_t       rdata;
    logic        fifo_wr_en;
    byte_t       fifo_din;
    logic        fifo_full;
    ctrl_regs_t  ctrl;
    net_cfg_t    net_cfg;
    trig_delay_t trig_delay;

    // Shadow model
    ctrl_regs_t  m_ctrl;
    byte_t       m_counter;
    ip_addr_t    m_ip;
    udp_port_t   m_port;
    trig_delay_t m_delay;
    int          m_ip_pos;
    int          m_port_pos;
    int          m_delay_pos;
    byte_t       m_fifo[$];
    int          m_ds_pos;
    logic        m_empty_at_start;

    // Expected read bytes in request order
    byte_t       exp_q[$];
    string       name_q[$];
    string       test_name;
    logic [15:0] lfsr_state;
    int          cycle_count = 0;
    logic        prev_ack = 1'b0;
    byte_t       prev_rdata = '0;

    regfile_top u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .req_data   (req_data),
        .ack        (ack),
        .rdata      (rdata),
        .fifo_wr_en (fifo_wr_en),
        .fifo_din   (fifo_din),
        .fifo_full  (fifo_full),
        .ctrl       (ctrl),
        .net_cfg    (net_cfg),
        .trig_delay (trig_delay)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //----------------------------
    // Failure reporting and compare tasks
    //----------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("Error: %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            stop_run($sformatf("Error: %s expected 0x%02h actual 0x%02h", name, exp, act));
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_regs_t exp, input ctrl_regs_t act);
        if (act !== exp) begin
            stop_run($sformatf("Error: %s ctrl expected 0x%06h actual 0x%06h", name, exp, act));
        end
    endtask

    task automatic check_net(input string name, input net_cfg_t exp, input net_cfg_t act);
        if (act !== exp) begin
            stop_run($sformatf("Error: %s net_cfg expected 0x%012h actual 0x%012h",
                               name, exp, act));
        end
    endtask

    task automatic check_delay(input string name, input trig_delay_t exp,
                               input trig_delay_t act);
        if (act !== exp) begin
            stop_run($sformatf("Error: %s trig_delay expected 0x%06h actual 0x%06h",
                               name, exp, act));
        end
    endtask

    task automatic check_outputs();
        check_ctrl(test_name, m_ctrl, ctrl);
        check_net(test_name, {m_ip, m_port}, net_cfg);
        check_delay(test_name, m_delay, trig_delay);
        check_bit({test_name, " fifo_full"}, m_fifo.size() == FIFO_DEPTH, fifo_full);
    endtask

    //----------------------------
    // Random bytes and reference model
    //----------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic rand_byte(output byte_t b);
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic fr_takes_data();
        return (m_fifo.size() != 0) && (m_ds_pos == 0 || !m_empty_at_start);
    endfunction

    function automatic byte_t ref_read(input addr_t a);
        byte_t r;
        case (a)
            `ADDR_CHIP_CONFIG: r = m_ctrl.chip_config;
            `ADDR_COUNTER:     r = m_counter;
            `ADDR_FR_CONTROL:  r = m_ctrl.fr_control;
            `ADDR_TRIG_CONFIG: r = m_ctrl.trig_config;
            `ADDR_TEST:        r = `TEST_BYTE;
            `ADDR_FR_STATUS:   r = {6'b0, m_fifo.size() == FIFO_DEPTH, m_fifo.size() == 0};
            `ADDR_FR_DATA:     r = fr_takes_data() ? m_fifo[0] : `FILL_BYTE;
            `ADDR_ETH_IP:      r = m_ip[8*(3-m_ip_pos) +: 8];
            `ADDR_ETH_PORT:    r = m_port[8*(1-m_port_pos) +: 8];
            `ADDR_TRIG_DELAY:  r = m_delay[8*(2-m_delay_pos) +: 8];
            default:           r = 8'h00;
        endcase
        return r;
    endfunction

    task automatic model_write(input addr_t a, input byte_t d);
        case (a)
            `ADDR_CHIP_CONFIG: m_ctrl.chip_config = d;
            `ADDR_FR_CONTROL:  m_ctrl.fr_control = d;
            `ADDR_TRIG_CONFIG: m_ctrl.trig_config = d;
            `ADDR_ETH_IP:      m_ip = {m_ip[23:0], d};
            `ADDR_ETH_PORT:    m_port = {m_port[7:0], d};
            `ADDR_TRIG_DELAY:  m_delay = {m_delay[15:0], d};
            default: ;
        endcase
    endtask

    task automatic model_read(input addr_t a);
        logic take;
        take = fr_takes_data();
        case (a)
            `ADDR_COUNTER:    m_counter = m_counter + 8'd1;
            `ADDR_ETH_IP:     m_ip_pos = (m_ip_pos + 1) % 4;
            `ADDR_ETH_PORT:   m_port_pos = (m_port_pos + 1) % 2;
            `ADDR_TRIG_DELAY: m_delay_pos = (m_delay_pos + 1) % 3;
            `ADDR_FR_DATA: begin
                if (m_ds_pos == 0) begin
                    m_empty_at_start = (m_fifo.size() == 0);
                end
                if (take) begin
                    void'(m_fifo.pop_front());
                end
                m_ds_pos = (m_ds_pos + 1) % DATASET_LEN;
            end
            default: ;
        endcase
    endtask

    //----------------------------
    // Bus and FIFO drivers
    //----------------------------
    // hold keeps req high for extra cycles after ack
    task automatic bus_xfer(input logic wr, input addr_t a, input byte_t d, input int hold);
        if (!wr) begin
            exp_q.push_back(ref_read(a));
            name_q.push_back($sformatf("%s read addr %0d", test_name, a));
        end
        @(posedge clk);
        req      <= 1'b1;
        req_data <= '{write: wr, addr: a, wdata: d};
        @(posedge clk);
        while (ack !== 1'b1) begin
            @(posedge clk);
        end
        repeat (hold) @(posedge clk);
        req <= 1'b0;
        while (ack !== 1'b0) begin
            @(posedge clk);
        end
        if (wr) begin
            model_write(a, d);
        end else begin
            model_read(a);
        end
    endtask

    task automatic write_reg(input addr_t a, input byte_t d);
        bus_xfer(1'b1, a, d, 0);
    endtask

    task automatic read_reg(input addr_t a);
        bus_xfer(1'b0, a, 8'h00, 0);
    endtask

    task automatic push_fifo(input byte_t d);
        @(posedge clk);
        fifo_wr_en <= 1'b1;
        fifo_din   <= d;
        @(posedge clk);
        fifo_wr_en <= 1'b0;
        if (m_fifo.size() < FIFO_DEPTH) begin
            m_fifo.push_back(d);
        end
    endtask

    //----------------------------
    // Handshake monitor and read compare
    //----------------------------
    always @(posedge clk) begin
        if (arst_n) begin
            if (ack && !prev_ack) begin
                if (!req) begin
                    stop_run("Handshake: ack rose while req was low");
                end else if (!req_data.write) begin
                    if (exp_q.size() == 0) begin
                        stop_run("A read was acknowledged that the testbench never issued");
                    end else begin
                        check_byte(name_q.pop_front(), exp_q.pop_front(), rdata);
                    end
                end
            end
            if (!ack && prev_ack && req) begin
                stop_run("Handshake: ack fell while req was still high");
            end
            if (ack && prev_ack && rdata !== prev_rdata) begin
                stop_run("Handshake: rdata changed while ack was high");
            end
        end
        prev_ack   <= ack;
        prev_rdata <= rdata;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            stop_run("Timeout: the run did not finish within the cycle limit");
        end
    end

    //----------------------------
    // Directed tests
    //----------------------------
    initial begin
        byte_t b;
        arst_n     = 1'b0;
        req        = 1'b0;
        req_data   = '0;
        fifo_wr_en = 1'b0;
        fifo_din   = '0;
        lfsr_state = 16'd22;
        m_ctrl     = '{chip_config: 8'h00, fr_control: `RST_FR_CONTROL,
                       trig_config: `RST_TRIG_CONFIG};
        m_counter  = `RST_COUNTER;
        m_ip       = `RST_ETH_IP;
        m_port     = `RST_ETH_PORT;
        m_delay    = `RST_TRIG_DELAY;
        m_ip_pos   = 0;
        m_port_pos = 0;
        m_delay_pos = 0;
        m_ds_pos   = 0;
        m_empty_at_start = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        test_name = "reset";
        check_bit("reset ack", 1'b0, ack);
        check_byte("reset rdata", 8'h00, rdata);
        check_outputs();
        read_reg(`ADDR_CHIP_CONFIG);
        read_reg(`ADDR_COUNTER);
        read_reg(`ADDR_FR_CONTROL);
        read_reg(`ADDR_FR_STATUS);
        read_reg(`ADDR_TRIG_CONFIG);
        read_reg(`ADDR_TEST);
        read_reg(ADDR_UNMAPPED);
        for (int i = 0; i < 4; i++) begin
            read_reg(`ADDR_ETH_IP);
        end
        for (int i = 0; i < 2; i++) begin
            read_reg(`ADDR_ETH_PORT);
        end
        for (int i = 0; i < 3; i++) begin
            read_reg(`ADDR_TRIG_DELAY);
        end

        test_name = "single-byte";
        for (int i = 0; i < 4; i++) begin
            rand_byte(b);
            write_reg(`ADDR_CHIP_CONFIG, b);
            rand_byte(b);
            write_reg(`ADDR_FR_CONTROL, b);
            rand_byte(b);
            write_reg(`ADDR_TRIG_CONFIG, b);
            read_reg(`ADDR_CHIP_CONFIG);
            read_reg(`ADDR_FR_CONTROL);
            read_reg(`ADDR_TRIG_CONFIG);
            check_outputs();
        end
        // Read-only and unmapped writes
        rand_byte(b);
        write_reg(`ADDR_TEST, b);
        write_reg(ADDR_UNMAPPED, b);
        read_reg(`ADDR_TEST);
        read_reg(ADDR_UNMAPPED);
        read_reg(`ADDR_CHIP_CONFIG);
        read_reg(`ADDR_FR_CONTROL);
        read_reg(`ADDR_TRIG_CONFIG);
        check_outputs();

        test_name = "multi-byte";
        for (int i = 0; i < 4; i++) begin
            rand_byte(b);
            write_reg(`ADDR_ETH_IP, b);
        end
        for (int i = 0; i < 2; i++) begin
            rand_byte(b);
            write_reg(`ADDR_ETH_PORT, b);
        end
        for (int i = 0; i < 3; i++) begin
            rand_byte(b);
            write_reg(`ADDR_TRIG_DELAY, b);
        end
        check_outputs();
        // A write between reads must not move the read position
        read_reg(`ADDR_ETH_IP);
        rand_byte(b);
        write_reg(`ADDR_ETH_IP, b);
        check_outputs();
        for (int i = 0; i < 7; i++) begin
            read_reg(`ADDR_ETH_IP);
        end
        for (int i = 0; i < 4; i++) begin
            read_reg(`ADDR_ETH_PORT);
        end
        for (int i = 0; i < 6; i++) begin
            read_reg(`ADDR_TRIG_DELAY);
        end

        test_name = "counter";
        for (int i = 0; i < 6; i++) begin
            bus_xfer(1'b0, `ADDR_COUNTER, 8'h00, i);
        end

        test_name = "dataset empty";
        read_reg(`ADDR_FR_STATUS);
        for (int i = 0; i < DATASET_LEN; i++) begin
            read_reg(`ADDR_FR_DATA);
        end

        test_name = "dataset data";
        for (int i = 0; i < 5; i++) begin
            rand_byte(b);
            push_fifo(b);
        end
        read_reg(`ADDR_FR_STATUS);
        for (int i = 0; i < DATASET_LEN; i++) begin
            read_reg(`ADDR_FR_DATA);
        end
        read_reg(`ADDR_FR_STATUS);

        // One push beyond the depth is dropped
        test_name = "fifo full";
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            rand_byte(b);
            push_fifo(b);
        end
        check_outputs();
        read_reg(`ADDR_FR_STATUS);
        for (int i = 0; i < 3 * DATASET_LEN; i++) begin
            read_reg(`ADDR_FR_DATA);
        end
        read_reg(`ADDR_FR_STATUS);
        check_outputs();

        @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: regfile_top.sv
//----------------------------
// Byte-wide register file for the readout board
// Single clock, four-phase req/ack host bus
// Unmapped reads return 0, unmapped writes are ignored
//----------------------------
`timescale 1ns/1ps
`include "regfile_settings.svh"

module regfile_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     req,
    input  regfile_pkg::bus_req_t    req_data,
    output logic                     ack,
    output regfile_pkg::byte_t       rdata,
    input  logic                     fifo_wr_en,
    input  regfile_pkg::byte_t       fifo_din,
    output logic                     fifo_full,
    output regfile_pkg::ctrl_regs_t  ctrl,
    output regfile_pkg::net_cfg_t    net_cfg,
    output regfile_pkg::trig_delay_t trig_delay
);
    import regfile_pkg::*;

    logic      access;
    logic      ctrl_hit;
    byte_t     ctrl_rdata;
    byte_t     target_rdata;
    byte_t     status_byte;

    logic      sel_ip;
    logic      sel_port;
    logic      sel_delay;
    logic      fr_rd;
    byte_t     ip_byte;
    byte_t     port_byte;
    byte_t     delay_byte;
    ip_addr_t  ip_value;
    udp_port_t port_value;

    logic      fifo_empty;
    logic      fifo_pop;
    byte_t     fifo_dout;
    byte_t     fr_rdata;

    //----------------------------
    // Address decode
    //----------------------------
    assign sel_ip    = access && (req_data.addr == `ADDR_ETH_IP);
    assign sel_port  = access && (req_data.addr == `ADDR_ETH_PORT);
    assign sel_delay = access && (req_data.addr == `ADDR_TRIG_DELAY);
    assign fr_rd     = access && !req_data.write && (req_data.addr == `ADDR_FR_DATA);

    assign status_byte = {6'b0, fifo_full, fifo_empty};
    assign net_cfg     = {ip_value, port_value};

    // Read data select
    always_comb begin
        case (req_data.addr)
            `ADDR_FR_STATUS:  target_rdata = status_byte;
            `ADDR_FR_DATA:    target_rdata = fr_rdata;
            `ADDR_ETH_IP:     target_rdata = ip_byte;
            `ADDR_ETH_PORT:   target_rdata = port_byte;
            `ADDR_TRIG_DELAY: target_rdata = delay_byte;
            default:          target_rdata = ctrl_hit ? ctrl_rdata : '0;
        endcase
    end

    //----------------------------
    // Blocks
    //----------------------------
    bus_port u_bus_port (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req),
        .req_data     (req_data),
        .ack          (ack),
        .access       (access),
        .target_rdata (target_rdata),
        .rdata        (rdata)
    );

    ctrl_regs u_ctrl_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .access     (access),
        .req_data   (req_data),
        .ctrl       (ctrl),
        .ctrl_hit   (ctrl_hit),
        .ctrl_rdata (ctrl_rdata)
    );

    multibyte_reg #(.NBYTES(4), .RST_VALUE(`RST_ETH_IP)) u_eth_ip (
        .clk    (clk),
        .arst_n (arst_n),
        .sel    (sel_ip),
        .write  (req_data.write),
        .wdata  (req_data.wdata),
        .value  (ip_value),
        .rbyte  (ip_byte)
    );

    multibyte_reg #(.NBYTES(2), .RST_VALUE(`RST_ETH_PORT)) u_eth_port (
        .clk    (clk),
        .arst_n (arst_n),
        .sel    (sel_port),
        .write  (req_data.write),
        .wdata  (req_data.wdata),
        .value  (port_value),
        .rbyte  (port_byte)
    );

    multibyte_reg #(.NBYTES(3), .RST_VALUE(`RST_TRIG_DELAY)) u_trig_delay (
        .clk    (clk),
        .arst_n (arst_n),
        .sel    (sel_delay),
        .write  (req_data.write),
        .wdata  (req_data.wdata),
        .value  (trig_delay),
        .rbyte  (delay_byte)
    );

    readout_fifo u_readout_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .wr_en  (fifo_wr_en),
        .din    (fifo_din),
        .rd_en  (fifo_pop),
        .dout   (fifo_dout),
        .empty  (fifo_empty),
        .full   (fifo_full)
    );

    dataset_reader u_dataset_reader (
        .clk        (clk),
        .arst_n     (arst_n),
        .fr_rd      (fr_rd),
        .fifo_empty (fifo_empty),
        .fifo_dout  (fifo_dout),
        .fifo_pop   (fifo_pop),
        .fr_rdata   (fr_rdata)
    );

endmodule

// File: dataset_reader.sv
//----------------------------
// Fast-readout dataset reader
// Dataset of DATASET_LEN reads, fill bytes when it began empty
// Data arriving mid-dataset waits for the next one
//----------------------------
`timescale 1ns/1ps
`include "regfile_settings.svh"

module dataset_reader (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               fr_rd,
    input  logic               fifo_empty,
    input  regfile_pkg::byte_t fifo_dout,
    output logic               fifo_pop,
    output regfile_pkg::byte_t fr_rdata
);

    localparam int LEN = `DATASET_LEN;
    localparam int PW  = (LEN > 1) ? $clog2(LEN) : 1;

    logic [PW-1:0] pos;
    logic          empty_at_start;
    logic          at_start;
    logic          load;

    assign at_start = (pos == '0);

    // Take FIFO data only if some was there when the dataset began
    assign load     = !fifo_empty && (at_start || !empty_at_start);
    assign fifo_pop = fr_rd && load;
    assign fr_rdata = load ? fifo_dout : `FILL_BYTE;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pos            <= '0;
            empty_at_start <= 1'b0;
        end else if (fr_rd) begin
            if (at_start) begin
                empty_at_start <= fifo_empty;
            end
            if (pos == PW'(LEN - 1)) begin
                pos <= '0;
            end else begin
                pos <= pos + 1'b1;
            end
        end
    end

endmodule

// File: readout_fifo.sv
//----------------------------
// Single-clock byte FIFO, first-word fall-through
// Write while full and pop while empty are dropped
//----------------------------
`timescale 1ns/1ps
`include "regfile_settings.svh"

module readout_fifo (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               wr_en,
    input  regfile_pkg::byte_t din,
    input  logic               rd_en,
    output regfile_pkg::byte_t dout,
    output logic               empty,
    output logic               full
);
    import regfile_pkg::*;

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    byte_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;
    assign dout  = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap at DEPTH
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: multibyte_reg.sv
//----------------------------
// Shift-in register of NBYTES bytes
// Writes enter at the low byte, reads rotate from the high byte
// Writes leave the read position alone
//----------------------------
`timescale 1ns/1ps

module multibyte_reg #(
    parameter int                  NBYTES    = 4,
    parameter logic [NBYTES*8-1:0] RST_VALUE = '0
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                sel,
    input  logic                write,
    input  regfile_pkg::byte_t  wdata,
    output logic [NBYTES*8-1:0] value,
    output regfile_pkg::byte_t  rbyte
);

    localparam int POS_W = (NBYTES > 1) ? $clog2(NBYTES) : 1;

    logic [POS_W-1:0]     rd_pos;
    logic [NBYTES*8+7:0]  shifted;
    logic                 last_pos;

    // Old value moves up one byte, top byte drops out
    assign shifted  = {value, wdata};
    assign last_pos = (rd_pos == POS_W'(NBYTES - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            value  <= RST_VALUE;
            rd_pos <= '0;
        end else if (sel) begin
            if (write) begin
                value <= shifted[NBYTES*8-1:0];
            end else if (last_pos) begin
                rd_pos <= '0;
            end else begin
                rd_pos <= rd_pos + 1'b1;
            end
        end
    end

    // Position 0 is the most significant byte
    always_comb begin
        rbyte = value[8*(NBYTES-1-int'(rd_pos)) +: 8];
    end

endmodule

// File: ctrl_regs.sv
//----------------------------
// Single-byte registers, read counter and test register
// Counter returns its value, then steps by one per read
// Test address is read only
//----------------------------
`timescale 1ns/1ps
`include "regfile_settings.svh"

module ctrl_regs (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   access,
    input  regfile_pkg::bus_req_t  req_data,
    output regfile_pkg::ctrl_regs_t ctrl,
    output logic                   ctrl_hit,
    output regfile_pkg::byte_t     ctrl_rdata
);
    import regfile_pkg::*;

    byte_t counter;
    logic  wr_strobe;
    logic  rd_strobe;

    assign wr_strobe = access && req_data.write;
    assign rd_strobe = access && !req_data.write;

    //----------------------------
    // Register updates
    //----------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl.chip_config <= '0;
            ctrl.fr_control  <= `RST_FR_CONTROL;
            ctrl.trig_config <= `RST_TRIG_CONFIG;
            counter          <= `RST_COUNTER;
        end else begin
            if (wr_strobe) begin
                case (req_data.addr)
                    `ADDR_CHIP_CONFIG: ctrl.chip_config <= req_data.wdata;
                    `ADDR_FR_CONTROL:  ctrl.fr_control  <= req_data.wdata;
                    `ADDR_TRIG_CONFIG: ctrl.trig_config <= req_data.wdata;
                    default: ;
                endcase
            end
            // Step after the current value has been returned
            if (rd_strobe && req_data.addr == `ADDR_COUNTER) begin
                counter <= counter + 8'd1;
            end
        end
    end

    //----------------------------
    // Decode and read mux
    //----------------------------
    always_comb begin
        ctrl_hit   = 1'b1;
        ctrl_rdata = '0;
        case (req_data.addr)
            `ADDR_CHIP_CONFIG: ctrl_rdata = ctrl.chip_config;
            `ADDR_COUNTER:     ctrl_rdata = counter;
            `ADDR_FR_CONTROL:  ctrl_rdata = ctrl.fr_control;
            `ADDR_TRIG_CONFIG: ctrl_rdata = ctrl.trig_config;
            `ADDR_TEST:        ctrl_rdata = `TEST_BYTE;
            default: begin
                ctrl_hit = 1'b0;
            end
        endcase
    end

endmodule

// File: bus_port.sv
//----------------------------
// Four-phase req/ack bus engine
// One access strobe per transaction, however long req is held
// rdata only changes on the edge where ack rises
//----------------------------
`timescale 1ns/1ps

module bus_port (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req,
    input  regfile_pkg::bus_req_t req_data,
    output logic                 ack,
    output logic                 access,
    input  regfile_pkg::byte_t   target_rdata,
    output regfile_pkg::byte_t   rdata
);
    import regfile_pkg::*;

    bus_state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            ack    <= 1'b0;
            access <= 1'b0;
            rdata  <= '0;
        end else begin
            access <= 1'b0;
            case (state)
                IDLE: begin
                    ack <= 1'b0;
                    if (access) begin
                        // Targets act on this edge, read byte is taken here
                        ack   <= 1'b1;
                        state <= ACK;
                        if (!req_data.write) begin
                            rdata <= target_rdata;
                        end
                    end else if (req && !ack) begin
                        access <= 1'b1;
                    end
                end
                ACK: begin
                    // Hold ack until the master lets go of req
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: regfile_pkg.sv
//----------------------------
// Types shared by the register file blocks
// Bus is byte wide with 8-bit addresses
//----------------------------
package regfile_pkg;

    // One data byte and one register address
    typedef logic [7:0] byte_t;
    typedef logic [7:0] addr_t;

    // Multi-byte register values
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [23:0] trig_delay_t;

    // One bus transaction, held stable while req is high
    typedef struct packed {
        logic  write;
        addr_t addr;
        byte_t wdata;
    } bus_req_t;

    // Single-byte configuration outputs
    typedef struct packed {
        byte_t chip_config;
        byte_t fr_control;
        byte_t trig_config;
    } ctrl_regs_t;

    // Ethernet settings
    typedef struct packed {
        ip_addr_t  ip;
        udp_port_t port;
    } net_cfg_t;

    // Handshake engine states
    typedef enum logic {
        IDLE,
        ACK
    } bus_state_t;

endpackage

// File: regfile_settings.svh
//----------------------------
// Address map, reset values and sizes of the register file
// Addresses are 8 bits wide and must stay unique
// FIFO_DEPTH and DATASET_LEN need not be powers of two
//----------------------------
`ifndef REGFILE_SETTINGS_SVH
`define REGFILE_SETTINGS_SVH

// Address map
`define ADDR_CHIP_CONFIG  8'd0
`define ADDR_COUNTER      8'd8
`define ADDR_FR_CONTROL   8'd9
`define ADDR_FR_STATUS    8'd10
`define ADDR_FR_DATA      8'd11
`define ADDR_ETH_IP       8'd30
`define ADDR_ETH_PORT     8'd31
`define ADDR_TRIG_CONFIG  8'd40
`define ADDR_TRIG_DELAY   8'd41
`define ADDR_TEST         8'd80

// Reset values
`define RST_FR_CONTROL    8'h80
`define RST_TRIG_CONFIG   8'd16
`define RST_COUNTER       8'd17
`define RST_ETH_IP        {8'd192, 8'd168, 8'd1, 8'd128}
`define RST_ETH_PORT      16'd1234
`define RST_TRIG_DELAY    24'd0

// Constants and sizes
`define TEST_BYTE         8'hAB
`define FILL_BYTE         8'hFF
`define DATASET_LEN       8
`define FIFO_DEPTH        16

`endif
